/* common/acc_cpu_defines.svh */
`ifndef ACC_CPU_DEFINES_SVH
`define ACC_CPU_DEFINES_SVH

// data and instruction word width
`define ACC_DW 16
// memory word address, 2048 words
`define ACC_MEM_AW 11
// control form argument width
`define ACC_ARG_W 12

// host bus widths
`define ACC_HOST_AW 16
`define ACC_AXI_DW 32

// host register map, memory window sits below CTRL
`define ACC_REG_CTRL 16'h2000
`define ACC_REG_STATUS 16'h2004
`define ACC_REG_ACC 16'h2008
`define ACC_REG_PC 16'h200C

// axi response codes
`define ACC_AXI_OKAY 2'b00
`define ACC_AXI_SLVERR 2'b10

`endif

/* common/acc_cpu_pkg.sv */
`default_nettype none

`include "acc_cpu_defines.svh"

package acc_cpu_pkg;

    // alu opcodes, same order as the original unit
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_DIV,
        ALU_SHL,
        ALU_SHR,
        ALU_ROL,
        ALU_ROR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_NAND,
        ALU_XNOR,
        ALU_GT,
        ALU_EQ
    } alu_op_e;

    // control opcodes, 6 and 7 left illegal
    typedef enum logic [2:0] {
        CTRL_LOAD  = 3'd0,
        CTRL_STORE = 3'd1,
        CTRL_LOADI = 3'd2,
        CTRL_JUMP  = 3'd3,
        CTRL_JUMPZ = 3'd4,
        CTRL_HALT  = 3'd5
    } ctrl_op_e;

    // mode clear: acc = acc op mem[addr]
    typedef struct packed {
        logic                   mode;
        alu_op_e                op;
        logic [`ACC_MEM_AW-1:0] addr;
    } alu_instr_t;

    // mode set: control op with address or immediate
    typedef struct packed {
        logic                  mode;
        ctrl_op_e              op;
        logic [`ACC_ARG_W-1:0] arg;
    } ctrl_instr_t;

    typedef union packed {
        alu_instr_t  alu;
        ctrl_instr_t ctrl;
    } instr_u;

    // one memory port request
    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [`ACC_MEM_AW-1:0] addr;
        logic [`ACC_DW-1:0]     wdata;
    } mem_req_t;

    typedef struct packed {
        logic busy;
        logic halted;
        logic illegal;
    } core_status_t;

endpackage

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_defines.svh"

module alu (
    input  acc_cpu_pkg::alu_op_e op,
    input  logic [`ACC_DW-1:0]   a,
    input  logic [`ACC_DW-1:0]   b,
    output logic [`ACC_DW-1:0]   result
);
    import acc_cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            // low half of the product only
            ALU_MUL: result = a * b;
            // divide by zero saturates to all ones
            ALU_DIV: result = (b == '0) ? '1 : a / b;
            // shifts and rotates move a by one, b unused
            ALU_SHL: result = a << 1;
            ALU_SHR: result = a >> 1;
            ALU_ROL: result = {a[`ACC_DW-2:0], a[`ACC_DW-1]};
            ALU_ROR: result = {a[0], a[`ACC_DW-1:1]};
            ALU_AND: result = a & b;
            ALU_OR: result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOR: result = ~(a | b);
            ALU_NAND: result = ~(a & b);
            ALU_XNOR: result = ~(a ^ b);
            // unsigned compares give 1 or 0
            ALU_GT: result = (a > b) ? `ACC_DW'(1) : '0;
            ALU_EQ: result = (a == b) ? `ACC_DW'(1) : '0;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* core/acc_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_defines.svh"

module acc_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output acc_cpu_pkg::mem_req_t     mem_req,
    input  logic [`ACC_DW-1:0]        mem_rdata,
    output acc_cpu_pkg::alu_op_e      alu_op,
    output logic [`ACC_DW-1:0]        alu_a,
    output logic [`ACC_DW-1:0]        alu_b,
    input  logic [`ACC_DW-1:0]        alu_result,
    output acc_cpu_pkg::core_status_t status,
    output logic [`ACC_DW-1:0]        acc,
    output logic [`ACC_MEM_AW-1:0]    pc
);
    import acc_cpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DECODE,
        EXECUTE
    } state_e;

    state_e                 state_q;
    instr_u                 ir_q;
    core_status_t           status_q;
    logic [`ACC_DW-1:0]     acc_q;
    logic [`ACC_MEM_AW-1:0] pc_q;
    // second execute cycle, operand now on mem_rdata
    logic                   operand_q;

    logic                   is_alu;
    logic                   is_store;
    logic                   needs_read;
    logic [`ACC_MEM_AW-1:0] op_addr;

    // mode bit picks the union view
    assign is_alu = !ir_q.alu.mode;
    assign is_store = !is_alu && (ir_q.ctrl.op == CTRL_STORE);
    assign needs_read = is_alu || (ir_q.ctrl.op == CTRL_LOAD);
    // memory ops only use the low address bits of arg
    assign op_addr = is_alu ? ir_q.alu.addr : ir_q.ctrl.arg[`ACC_MEM_AW-1:0];

    // single core memory port
    always_comb begin
        mem_req = '0;
        if (state_q == FETCH) begin
            mem_req.en = 1'b1;
            mem_req.addr = pc_q;
        end else if (state_q == EXECUTE && !operand_q && (needs_read || is_store)) begin
            mem_req.en = 1'b1;
            mem_req.we = is_store;
            mem_req.addr = op_addr;
            mem_req.wdata = acc_q;
        end
    end

    // alu sees acc and the operand word straight from memory
    assign alu_op = ir_q.alu.op;
    assign alu_a = acc_q;
    assign alu_b = mem_rdata;

    // instruction word arrives one cycle after fetch
    always_ff @(posedge clk) begin
        if (state_q == DECODE) begin
            ir_q <= mem_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            status_q <= '0;
            acc_q <= '0;
            pc_q <= '0;
            operand_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // restart from address 0, acc kept
                    if (start) begin
                        pc_q <= '0;
                        status_q.busy <= 1'b1;
                        status_q.halted <= 1'b0;
                        status_q.illegal <= 1'b0;
                        state_q <= FETCH;
                    end
                end
                FETCH: begin
                    state_q <= DECODE;
                end
                DECODE: begin
                    // wraps from 2047 to 0
                    pc_q <= pc_q + 1'b1;
                    state_q <= EXECUTE;
                end
                EXECUTE: begin
                    state_q <= FETCH;
                    if (needs_read && !operand_q) begin
                        // read issued, wait one cycle for the data
                        operand_q <= 1'b1;
                        state_q <= EXECUTE;
                    end else if (is_alu) begin
                        operand_q <= 1'b0;
                        acc_q <= alu_result;
                    end else begin
                        operand_q <= 1'b0;
                        case (ir_q.ctrl.op)
                            CTRL_LOAD: acc_q <= mem_rdata;
                            // write goes out on mem_req this cycle
                            CTRL_STORE: acc_q <= acc_q;
                            CTRL_LOADI: acc_q <= {{(`ACC_DW - `ACC_ARG_W){1'b0}}, ir_q.ctrl.arg};
                            CTRL_JUMP: pc_q <= op_addr;
                            CTRL_JUMPZ: begin
                                if (acc_q == '0) begin
                                    pc_q <= op_addr;
                                end
                            end
                            CTRL_HALT: begin
                                status_q.busy <= 1'b0;
                                status_q.halted <= 1'b1;
                                state_q <= IDLE;
                            end
                            default: begin
                                // codes 6 and 7 stop the core and flag it
                                status_q.busy <= 1'b0;
                                status_q.halted <= 1'b1;
                                status_q.illegal <= 1'b1;
                                state_q <= IDLE;
                            end
                        endcase
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign status = status_q;
    assign acc = acc_q;
    assign pc = pc_q;

endmodule

`default_nettype wire

/* source/main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_defines.svh"

module main_memory (
    input  logic                  clk,
    input  acc_cpu_pkg::mem_req_t core_req,
    output logic [`ACC_DW-1:0]    core_rdata,
    input  acc_cpu_pkg::mem_req_t host_req,
    output logic [`ACC_DW-1:0]    host_rdata
);

    logic [`ACC_DW-1:0] mem [0:(1 << `ACC_MEM_AW)-1];

    // both ports in one process, host writes are held off while the core runs
    always_ff @(posedge clk) begin
        if (core_req.en) begin
            if (core_req.we) begin
                mem[core_req.addr] <= core_req.wdata;
            end else begin
                core_rdata <= mem[core_req.addr];
            end
        end
        // read data holds until the next read on this port
        if (host_req.en) begin
            if (host_req.we) begin
                mem[host_req.addr] <= host_req.wdata;
            end else begin
                host_rdata <= mem[host_req.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* source/axil_host_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_defines.svh"

module axil_host_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`ACC_HOST_AW-1:0]   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`ACC_AXI_DW-1:0]    wdata,
    input  logic [`ACC_AXI_DW/8-1:0]  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`ACC_HOST_AW-1:0]   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`ACC_AXI_DW-1:0]    rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output acc_cpu_pkg::mem_req_t     mem_req,
    input  logic [`ACC_DW-1:0]        mem_rdata,
    output logic                      start,
    input  acc_cpu_pkg::core_status_t status,
    input  logic [`ACC_DW-1:0]        acc,
    input  logic [`ACC_MEM_AW-1:0]    pc
);
    import acc_cpu_pkg::*;

    logic                    aw_ready_q;
    logic                    ar_ready_q;
    logic                    bvalid_q;
    logic [1:0]              bresp_q;
    logic                    rvalid_q;
    logic [1:0]              rresp_q;
    logic [`ACC_AXI_DW-1:0]  rdata_q;
    logic                    start_q;
    // pending host write, issued the cycle after acceptance
    mem_req_t                wr_req_q;
    logic                    rd_pend_q;
    logic [`ACC_HOST_AW-1:0] rd_addr_q;

    logic                    aw_fire;
    logic                    ar_fire;
    logic                    busy_now;
    logic [`ACC_HOST_AW-1:0] aw_word;
    logic [`ACC_HOST_AW-1:0] rd_word;
    logic [`ACC_AXI_DW-1:0]  rd_data_d;
    logic [1:0]              rd_resp_d;

    // aw and w only ever taken together
    assign aw_fire = awvalid && wvalid && aw_ready_q;
    assign ar_fire = arvalid && ar_ready_q;
    // count a start still in flight as busy
    assign busy_now = status.busy || start_q;
    assign aw_word = {awaddr[`ACC_HOST_AW-1:2], 2'b00};
    assign rd_word = {rd_addr_q[`ACC_HOST_AW-1:2], 2'b00};

    // host memory port, a read never meets a pending write
    always_comb begin
        mem_req = wr_req_q;
        if (ar_fire && araddr < `ACC_REG_CTRL) begin
            mem_req.en = 1'b1;
            mem_req.we = 1'b0;
            mem_req.addr = araddr[`ACC_MEM_AW+1:2];
        end
    end

    // read data mux, memory word is valid one cycle after the read
    always_comb begin
        rd_data_d = '0;
        rd_resp_d = `ACC_AXI_OKAY;
        if (rd_word < `ACC_REG_CTRL) begin
            rd_data_d[`ACC_DW-1:0] = mem_rdata;
        end else begin
            case (rd_word)
                `ACC_REG_CTRL: rd_data_d = '0;
                `ACC_REG_STATUS: rd_data_d[2:0] = {status.illegal, status.halted, status.busy};
                `ACC_REG_ACC: rd_data_d[`ACC_DW-1:0] = acc;
                `ACC_REG_PC: rd_data_d[`ACC_MEM_AW-1:0] = pc;
                default: rd_resp_d = `ACC_AXI_SLVERR;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_ready_q <= 1'b0;
            ar_ready_q <= 1'b0;
            bvalid_q <= 1'b0;
            bresp_q <= `ACC_AXI_OKAY;
            rvalid_q <= 1'b0;
            start_q <= 1'b0;
            wr_req_q <= '0;
            rd_pend_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            wr_req_q.en <= 1'b0;
            // write side, one outstanding at a time
            aw_ready_q <= !(aw_fire || (bvalid_q && !bready));
            if (aw_fire) begin
                bvalid_q <= 1'b1;
                bresp_q <= `ACC_AXI_OKAY;
                if (awaddr < `ACC_REG_CTRL) begin
                    // memory is locked while the program runs
                    if (busy_now) begin
                        bresp_q <= `ACC_AXI_SLVERR;
                    end else begin
                        wr_req_q.en <= 1'b1;
                        wr_req_q.we <= 1'b1;
                        wr_req_q.addr <= awaddr[`ACC_MEM_AW+1:2];
                        wr_req_q.wdata <= wdata[`ACC_DW-1:0];
                    end
                end else if (aw_word == `ACC_REG_CTRL) begin
                    start_q <= wdata[0] && !busy_now;
                end else if (aw_word > `ACC_REG_PC) begin
                    bresp_q <= `ACC_AXI_SLVERR;
                end
            end else if (bready) begin
                bvalid_q <= 1'b0;
            end
            // read side, also held off the cycle a write goes to memory
            ar_ready_q <= !(ar_fire || rd_pend_q || (rvalid_q && !rready) || aw_fire);
            rd_pend_q <= ar_fire;
            if (rd_pend_q) begin
                rvalid_q <= 1'b1;
            end else if (rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // read payload
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr_q <= araddr;
        end
        if (rd_pend_q) begin
            rdata_q <= rd_data_d;
            rresp_q <= rd_resp_d;
        end
    end

    assign awready = aw_ready_q;
    assign wready = aw_ready_q;
    assign bvalid = bvalid_q;
    assign bresp = bresp_q;
    assign arready = ar_ready_q;
    assign rvalid = rvalid_q;
    assign rdata = rdata_q;
    assign rresp = rresp_q;
    assign start = start_q;

endmodule

`default_nettype wire

/* source/acc_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_defines.svh"

module acc_cpu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ACC_HOST_AW-1:0]  s_axil_awaddr,
    input  logic                     s_axil_awvalid,
    output logic                     s_axil_awready,
    input  logic [`ACC_AXI_DW-1:0]   s_axil_wdata,
    input  logic [`ACC_AXI_DW/8-1:0] s_axil_wstrb,
    input  logic                     s_axil_wvalid,
    output logic                     s_axil_wready,
    output logic [1:0]               s_axil_bresp,
    output logic                     s_axil_bvalid,
    input  logic                     s_axil_bready,
    input  logic [`ACC_HOST_AW-1:0]  s_axil_araddr,
    input  logic                     s_axil_arvalid,
    output logic                     s_axil_arready,
    output logic [`ACC_AXI_DW-1:0]   s_axil_rdata,
    output logic [1:0]               s_axil_rresp,
    output logic                     s_axil_rvalid,
    input  logic                     s_axil_rready
);
    import acc_cpu_pkg::*;

    mem_req_t               host_req;
    mem_req_t               core_req;
    logic [`ACC_DW-1:0]     host_rdata;
    logic [`ACC_DW-1:0]     core_rdata;
    logic                   start;
    core_status_t           status;
    logic [`ACC_DW-1:0]     acc;
    logic [`ACC_MEM_AW-1:0] pc;
    alu_op_e                alu_op;
    logic [`ACC_DW-1:0]     alu_a;
    logic [`ACC_DW-1:0]     alu_b;
    logic [`ACC_DW-1:0]     alu_result;

    // host side, loads programs and controls the core
    axil_host_port u_host (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (s_axil_awaddr),
        .awvalid   (s_axil_awvalid),
        .awready   (s_axil_awready),
        .wdata     (s_axil_wdata),
        .wstrb     (s_axil_wstrb),
        .wvalid    (s_axil_wvalid),
        .wready    (s_axil_wready),
        .bresp     (s_axil_bresp),
        .bvalid    (s_axil_bvalid),
        .bready    (s_axil_bready),
        .araddr    (s_axil_araddr),
        .arvalid   (s_axil_arvalid),
        .arready   (s_axil_arready),
        .rdata     (s_axil_rdata),
        .rresp     (s_axil_rresp),
        .rvalid    (s_axil_rvalid),
        .rready    (s_axil_rready),
        .mem_req   (host_req),
        .mem_rdata (host_rdata),
        .start     (start),
        .status    (status),
        .acc       (acc),
        .pc        (pc)
    );

    acc_core u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .mem_req    (core_req),
        .mem_rdata  (core_rdata),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .status     (status),
        .acc        (acc),
        .pc         (pc)
    );

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    main_memory u_mem (
        .clk        (clk),
        .core_req   (core_req),
        .core_rdata (core_rdata),
        .host_req   (host_req),
        .host_rdata (host_rdata)
    );

endmodule

`default_nettype wire

/* verif/tb_acc_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "acc_cpu_defines.svh"

module tb_acc_cpu;

    logic                     clk;
    logic                     rst_n;
    logic [`ACC_HOST_AW-1:0]  s_axil_awaddr;
    logic                     s_axil_awvalid;
    logic                     s_axil_awready;
    logic [`ACC_AXI_DW-1:0]   s_axil_wdata;
    logic [`ACC_AXI_DW/8-1:0] s_axil_wstrb;
    logic                     s_axil_wvalid;
    logic                     s_axil_wready;
    logic [1:0]               s_axil_bresp;
    logic                     s_axil_bvalid;
    logic                     s_axil_bready;
    logic [`ACC_HOST_AW-1:0]  s_axil_araddr;
    logic                     s_axil_arvalid;
    logic                     s_axil_arready;
    logic [`ACC_AXI_DW-1:0]   s_axil_rdata;
    logic [1:0]               s_axil_rresp;
    logic                     s_axil_rvalid;
    logic                     s_axil_rready;

    // run bookkeeping
    string test_name;
    int    test_errors;
    int    pass_count;
    int    fail_count;
    int    file_errors;
    int    record_count;
    int    poll_count;
    int    watchdog_cycles;
    int    cycle_count;

    acc_cpu_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

    // 20 ns period
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    // aw and w together, then b with a random 0 to 3 cycle hold-off
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int delay;
        @(negedge clk);
        s_axil_awaddr = addr;
        s_axil_wdata = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid = 1'b1;
        // both readys are registered, stable at the falling edge
        while (!(s_axil_awready && s_axil_wready)) @(negedge clk);
        @(negedge clk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid = 1'b0;
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        s_axil_bready = 1'b1;
        while (!s_axil_bvalid) @(negedge clk);
        resp = s_axil_bresp;
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        @(negedge clk);
        s_axil_araddr = addr;
        s_axil_arvalid = 1'b1;
        while (!s_axil_arready) @(negedge clk);
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        s_axil_rready = 1'b1;
        while (!s_axil_rvalid) @(negedge clk);
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic read_check(input string what, input logic [15:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value(what, expected, data);
        check_value({what, " rresp"}, 32'(`ACC_AXI_OKAY), 32'(resp));
    endtask

    task automatic start_core();
        logic [1:0] resp;
        axil_write(`ACC_REG_CTRL, 32'h1, resp);
        check_value("start bresp", 32'(`ACC_AXI_OKAY), 32'(resp));
    endtask

    // poll status until halted, give up after 2000 cycles
    task automatic wait_halted();
        logic [31:0] data;
        logic [1:0]  resp;
        int          start_cycle;
        bit          timed_out;
        start_cycle = cycle_count;
        data = '0;
        timed_out = 1'b0;
        while (!data[1] && !timed_out) begin
            if (cycle_count - start_cycle > 2000) begin
                $display("test %s: core never halted within 2000 cycles", test_name);
                test_errors++;
                timed_out = 1'b1;
            end else begin
                axil_read(`ACC_REG_STATUS, data, resp);
            end
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
            pass_count++;
        end else begin
            $display("test %s failed with %0d errors", test_name, test_errors);
            fail_count++;
        end
    endtask

    task automatic run_record(input string kind, input string name, input logic [31:0] f1,
                              input logic [31:0] f2, input logic [31:0] f3);
        logic [1:0] resp;
        case (kind)
            "T": begin
                test_name = name;
                test_errors = 0;
            end
            // word index to byte address
            "W": begin
                axil_write({f1[13:0], 2'b00}, f2, resp);
                check_value("bresp", 32'(`ACC_AXI_OKAY), 32'(resp));
            end
            "X": begin
                axil_write(f1[15:0], f2, resp);
                check_value("bresp", f3, 32'(resp));
            end
            "B": start_core();
            "H": wait_halted();
            "G": begin
                start_core();
                wait_halted();
            end
            "A": read_check("acc", `ACC_REG_ACC, f1);
            "P": read_check("pc", `ACC_REG_PC, f1);
            "S": read_check("status", `ACC_REG_STATUS, f1);
            "M": read_check($sformatf("mem[%h]", f1[10:0]), {f1[13:0], 2'b00}, f2);
            "E": finish_test();
            default: begin
                $display("unknown record kind %s in the vector file", kind);
                file_errors++;
            end
        endcase
    endtask

    // first pass only counts records for the watchdog, second pass runs them
    task automatic process_file(input bit execute);
        int               fd;
        int               code;
        int               want;
        string            kind;
        string            name;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [8*160-1:0] skip_line;
        fd = $fopen("verif/acc_cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/acc_cpu_vectors.txt");
            file_errors++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                f1 = '0;
                f2 = '0;
                f3 = '0;
                want = 0;
                code = 0;
                case (kind)
                    "#": code = $fgets(skip_line, fd);
                    "T": begin
                        want = 1;
                        code = $fscanf(fd, "%s", name);
                    end
                    "A", "P", "S": begin
                        want = 1;
                        code = $fscanf(fd, "%h", f1);
                    end
                    "W", "M": begin
                        want = 2;
                        code = $fscanf(fd, "%h %h", f1, f2);
                    end
                    "X": begin
                        want = 3;
                        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    end
                    default: code = 0;
                endcase
                if (kind != "#") begin
                    if (!execute) begin
                        record_count++;
                        if (kind == "G" || kind == "H") begin
                            poll_count++;
                        end
                    end else begin
                        // field count has to fit the record kind
                        if (code != want) begin
                            $display("record %s in the vector file has missing fields", kind);
                            file_errors++;
                        end
                        run_record(kind, name, f1, f2, f3);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '1;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        test_name = "none";
        void'($urandom(7));
        process_file(1'b0);
        // reset and settle margin on top of the per record budget
        watchdog_cycles = record_count * 200 + poll_count * 2000 + 20;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        process_file(1'b1);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && file_errors == 0 && pass_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog, armed once the vector file has been counted
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/acc_cpu_vectors.txt */
# records: T name | W word data | X byte_addr data bresp | B start | H poll | G start and poll
# checks: A acc | P pc | S status | M word data | E end of test; all numbers hex
T mem_round_trip
    W 000 1234 W 7ff beef W 3a5 0f0f W 123 a5a5
    M 000 1234 M 7ff beef M 3a5 0f0f M 123 a5a5 E
# alu program: loadi a53, op against word 100 = 0306, store to 101, halt
T alu_add W 000 aa53 W 002 9101 W 003 d000 W 100 0306
    W 001 0100 G A 0d59 M 101 0d59 P 004 S 0002 E
T alu_sub W 001 0900 G A 074d M 101 074d E
T alu_mul W 001 1100 G A 36f2 M 101 36f2 E
T alu_div W 001 1900 G A 0003 M 101 0003 E
T alu_shl W 001 2100 G A 14a6 M 101 14a6 E
T alu_shr W 001 2900 G A 0529 M 101 0529 E
T alu_rol W 001 3100 G A 14a6 M 101 14a6 E
T alu_ror W 001 3900 G A 8529 M 101 8529 E
T alu_and W 001 4100 G A 0202 M 101 0202 E
T alu_or W 001 4900 G A 0b57 M 101 0b57 E
T alu_xor W 001 5100 G A 0955 M 101 0955 E
T alu_nor W 001 5900 G A f4a8 M 101 f4a8 E
T alu_nand W 001 6100 G A fdfd M 101 fdfd E
T alu_xnor W 001 6900 G A f6aa M 101 f6aa E
T alu_gt W 001 7100 G A 0001 M 101 0001 E
T alu_eq W 001 7900 G A 0000 M 101 0000 E
T alu_div_zero W 100 0000 W 001 1900 G A ffff M 101 ffff E
T alu_eq_true W 100 0a53 W 001 7900 G A 0001 M 101 0001 E
# countdown from 5: sub word 201, store to 200, jumpz 5, jump 1, halt at 5
T countdown W 000 a005 W 001 0a01 W 002 9200 W 003 c005 W 004 b001 W 005 d000
    W 201 0001 W 200 ffff G A 0000 M 200 0000 P 006 S 0002 E
# control code 6 at address 1
T illegal_op W 000 a123 W 001 e000 G S 0006 A 0123 P 002 E
# second start after the illegal halt
T restart W 000 a0bc W 001 9300 W 002 d000 G S 0002 A 00bc M 300 00bc P 003 E
# loop of 100 passes, writes land while the core is busy
T busy_protect W 000 a064 W 001 0a01 W 002 c004 W 003 b001 W 004 d000
    W 201 0001 W 100 1111 B
    X 0400 5555 2 X 2010 0000 2
    H M 100 1111 A 0000 P 005 S 0002 E

/* project.f */
+incdir+common
common/acc_cpu_pkg.sv
source/alu.sv
core/acc_core.sv
source/main_memory.sv
source/axil_host_port.sv
source/acc_cpu_top.sv
verif/tb_acc_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the accumulator cpu testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_acc_cpu \
    -o Vtb_acc_cpu

./obj_dir/Vtb_acc_cpu > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished clean"
